/* source/lsu_pkg.sv */
// Physical 32-bit addresses only; no MMU, no AMOs, no double-word or FP accesses
`default_nettype none

package lsu_pkg;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned BE_W          = XLEN / 8;
  localparam int unsigned TRANS_ID_BITS = 3;

  // Memory operations handled by the LSU
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LH  = 4'd1,
    LW  = 4'd2,
    LBU = 4'd3,
    LHU = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // Subset of the RISC-V exception causes
  typedef enum logic [3:0] {
    CAUSE_NONE          = 4'd0,
    CAUSE_LD_MISALIGNED = 4'd4,
    CAUSE_ST_MISALIGNED = 4'd6
  } exc_cause_e;

  // ------------------------------
  // Structs shared across the LSU
  // ------------------------------

  typedef struct packed {
    lsu_op_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [XLEN-1:0]          imm;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  typedef struct packed {
    logic                     valid;
    logic                     is_store;
    lsu_op_e                  op;
    logic [XLEN-1:0]          addr;
    logic [BE_W-1:0]          be;
    logic [XLEN-1:0]          wdata;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exception_t               ex;
  } lsu_req_t;

  // Address is word aligned, low two bits always zero
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
    logic            we;
  } mem_req_t;

  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    exception_t               ex;
  } lsu_result_t;

endpackage

`default_nettype wire

/* source/lsu_agu.sv */
// Purely combinational; only misalignment is detected, no access faults or overflow checks
`default_nettype none

module lsu_agu (
  input  lsu_pkg::fu_data_t fu_data_i,
  input  logic              valid_i,
  output lsu_pkg::lsu_req_t req_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] addr;
  logic [1:0]      size;
  logic            is_store;
  logic            misaligned;

  // Effective address, immediate is sign extended already
  assign addr = $unsigned($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));

  // Transfer size: 0 byte, 1 half-word, 2 word
  always_comb begin
    size     = 2'b00;
    is_store = 1'b0;
    case (fu_data_i.op)
      LB, LBU: size = 2'b00;
      LH, LHU: size = 2'b01;
      LW:      size = 2'b10;
      SB: begin
        size     = 2'b00;
        is_store = 1'b1;
      end
      SH: begin
        size     = 2'b01;
        is_store = 1'b1;
      end
      SW: begin
        size     = 2'b10;
        is_store = 1'b1;
      end
      default: ;
    endcase
  end

  assign misaligned = ((size == 2'b01) && addr[0]) ||
                      ((size == 2'b10) && (addr[1:0] != 2'b00));

  always_comb begin
    req_o          = '0;
    req_o.valid    = valid_i;
    req_o.is_store = is_store;
    req_o.op       = fu_data_i.op;
    req_o.addr     = addr;
    req_o.trans_id = fu_data_i.trans_id;
    // Store data moved onto its byte lane
    req_o.wdata    = fu_data_i.operand_b << {addr[1:0], 3'b000};
    case (size)
      2'b00:   req_o.be = 4'b0001 << addr[1:0];
      2'b01:   req_o.be = 4'b0011 << addr[1:0];
      default: req_o.be = 4'b1111;
    endcase
    if (misaligned) begin
      req_o.ex.valid = 1'b1;
      req_o.ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      req_o.ex.tval  = addr;
    end
  end

endmodule

`default_nettype wire

/* source/lsu_mem_ctrl.sv */
// One instruction in flight; memory must hold ack low when idle and return read data with ack
`default_nettype none

module lsu_mem_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  lsu_pkg::lsu_req_t            req_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  output logic                         mem_req_o,
  output lsu_pkg::mem_req_t            mem_cmd_o,
  input  logic                         mem_ack_i,
  input  logic [lsu_pkg::XLEN-1:0]     mem_rdata_i,
  output lsu_pkg::lsu_result_t         ld_res_o,
  output lsu_pkg::lsu_op_e             ld_op_o,
  output logic [1:0]                   ld_offset_o,
  output lsu_pkg::lsu_result_t         st_res_o
);

  import lsu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_ACK_LOW,
    ST_RESP
  } state_e;

  state_e          state_q;
  state_e          state_d;
  lsu_req_t        req_q;
  logic [XLEN-1:0] rdata_q;
  logic            accept;
  logic            resp;

  assign ready_o = (state_q == ST_IDLE);
  assign accept  = valid_i && ready_o;
  assign resp    = (state_q == ST_RESP);

  // ------------------------------
  // Handshake FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          // excepted requests never touch memory
          state_d = req_i.ex.valid ? ST_RESP : ST_REQ;
        end
      end
      ST_REQ: begin
        if (mem_ack_i) begin
          state_d = ST_WAIT_ACK_LOW;
        end
      end
      ST_WAIT_ACK_LOW: begin
        if (!mem_ack_i) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Stall register and read capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if ((state_q == ST_REQ) && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // ------------------------------
  // Memory port
  // ------------------------------
  assign mem_req_o       = (state_q == ST_REQ);
  assign mem_cmd_o.addr  = {req_q.addr[XLEN-1:2], 2'b00};
  assign mem_cmd_o.be    = req_q.be;
  assign mem_cmd_o.wdata = req_q.wdata;
  assign mem_cmd_o.we    = req_q.is_store;

  // ------------------------------
  // Result routing
  // ------------------------------
  always_comb begin
    ld_res_o          = '0;
    ld_res_o.valid    = resp && !req_q.is_store;
    ld_res_o.trans_id = req_q.trans_id;
    ld_res_o.result   = req_q.ex.valid ? '0 : rdata_q;
    ld_res_o.ex       = req_q.ex;

    // Stores return zero
    st_res_o          = '0;
    st_res_o.valid    = resp && req_q.is_store;
    st_res_o.trans_id = req_q.trans_id;
    st_res_o.ex       = req_q.ex;
  end

  assign ld_op_o     = req_q.op;
  assign ld_offset_o = req_q.addr[1:0];

endmodule

`default_nettype wire

/* source/lsu_load_align.sv */
// Combinational; assumes the raw word is lane-aligned as read from memory
`default_nettype none

module lsu_load_align (
  input  lsu_pkg::lsu_result_t res_i,
  input  lsu_pkg::lsu_op_e     op_i,
  input  logic [1:0]           offset_i,
  output lsu_pkg::lsu_result_t res_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] shifted;

  // Addressed byte moved down to bit 0
  assign shifted = res_i.result >> {offset_i, 3'b000};

  always_comb begin
    res_o = res_i;
    if (!res_i.ex.valid) begin
      case (op_i)
        LB:      res_o.result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
        LBU:     res_o.result = {{(XLEN-8){1'b0}}, shifted[7:0]};
        LH:      res_o.result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
        LHU:     res_o.result = {{(XLEN-16){1'b0}}, shifted[15:0]};
        default: res_o.result = res_i.result;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/lsu_pipe_reg.sv */
// No back-pressure; DEPTH 0 is a plain wire and ignores clock and reset
`default_nettype none

module lsu_pipe_reg #(
  parameter int unsigned DEPTH     = 1,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t d_o
);

  if (DEPTH == 0) begin : gen_wire
    assign d_o = d_i;
  end else begin : gen_regs
    payload_t stage_q [DEPTH];

    // Cleared so the valid bit starts low
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
// Single outstanding access; load and store results have no back-pressure
`default_nettype none

module lsu_top #(
  parameter int unsigned NR_LOAD_PIPE_REGS  = 1,
  parameter int unsigned NR_STORE_PIPE_REGS = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Issue port
  input  logic                     lsu_valid_i,
  input  lsu_pkg::fu_data_t        fu_data_i,
  output logic                     lsu_ready_o,
  // Data memory port, four-phase req/ack
  output logic                     mem_req_o,
  output lsu_pkg::mem_req_t        mem_cmd_o,
  input  logic                     mem_ack_i,
  input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
  // Results
  output lsu_pkg::lsu_result_t     load_res_o,
  output lsu_pkg::lsu_result_t     store_res_o
);

  import lsu_pkg::*;

  lsu_req_t    agu_req;
  lsu_result_t ld_raw;
  lsu_result_t ld_aligned;
  lsu_result_t st_raw;
  lsu_op_e     ld_op;
  logic [1:0]  ld_offset;

  lsu_agu agu_inst (
    .fu_data_i (fu_data_i),
    .valid_i   (lsu_valid_i),
    .req_o     (agu_req)
  );

  lsu_mem_ctrl mem_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (agu_req),
    .valid_i     (lsu_valid_i),
    .ready_o     (lsu_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_cmd_o   (mem_cmd_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .ld_res_o    (ld_raw),
    .ld_op_o     (ld_op),
    .ld_offset_o (ld_offset),
    .st_res_o    (st_raw)
  );

  lsu_load_align load_align_inst (
    .res_i    (ld_raw),
    .op_i     (ld_op),
    .offset_i (ld_offset),
    .res_o    (ld_aligned)
  );

  // ------------------------------
  // Return path pipelines
  // ------------------------------
  lsu_pipe_reg #(
    .DEPTH     (NR_LOAD_PIPE_REGS),
    .payload_t (lsu_result_t)
  ) load_pipe_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_aligned),
    .d_o    (load_res_o)
  );

  lsu_pipe_reg #(
    .DEPTH     (NR_STORE_PIPE_REGS),
    .payload_t (lsu_result_t)
  ) store_pipe_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_raw),
    .d_o    (store_res_o)
  );

endmodule

`default_nettype wire

/* test/lsu_top_sva.sv */
// Bound into lsu_top; assumes the memory drops ack only after the request has fallen
`default_nettype none

module lsu_top_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              lsu_ready_o,
  input logic              mem_req_o,
  input lsu_pkg::mem_req_t mem_cmd_o,
  input logic              mem_ack_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Four-phase memory handshake
  // ------------------------------
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o)
    else $error("mem_req_o dropped before mem_ack_i");

  cmd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_cmd_o))
    else $error("mem_cmd_o changed while mem_req_o was high");

  // New request only once the previous ack is gone
  no_req_on_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_o) |-> !$past(mem_ack_i))
    else $error("mem_req_o raised while mem_ack_i still high");

  busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> !lsu_ready_o)
    else $error("lsu_ready_o high during a memory request");

endmodule

bind lsu_top lsu_top_sva lsu_top_sva_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .lsu_ready_o (lsu_ready_o),
  .mem_req_o   (mem_req_o),
  .mem_cmd_o   (mem_cmd_o),
  .mem_ack_i   (mem_ack_i)
);

`default_nettype wire

/* test/tb_lsu_top.sv */
// Default pipe depths of one; the memory model covers only the low 256 bytes of the address space
`default_nettype none

module tb_lsu_top;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  typedef struct packed {
    lsu_op_e         op;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] wdata;
    logic [2:0]      id;
    logic [XLEN-1:0] exp_res;
    logic            exp_ex;
    exc_cause_e      exp_cause;
    logic [XLEN-1:0] exp_tval;
  } vector_t;

  localparam int NUM_VEC    = 19;
  localparam int MAX_CYCLES = 8 + NUM_VEC * 24;

  logic            clk_i;
  logic            rst_ni;
  logic            lsu_valid_i;
  fu_data_t        fu_data_i;
  logic            lsu_ready_o;
  logic            mem_req_o;
  mem_req_t        mem_cmd_o;
  logic            mem_ack_i;
  logic [XLEN-1:0] mem_rdata_i;
  lsu_result_t     load_res_o;
  lsu_result_t     store_res_o;

  vector_t         vecs [NUM_VEC];
  logic [XLEN-1:0] mem [64];
  logic [31:0]     lfsr;
  int              cycles;
  int              results;
  int              dual_results;
  int              handshakes;

  lsu_top #(
    .NR_LOAD_PIPE_REGS  (1),
    .NR_STORE_PIPE_REGS (1)
  ) lsu_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_valid_i (lsu_valid_i),
    .fu_data_i   (fu_data_i),
    .lsu_ready_o (lsu_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_cmd_o   (mem_cmd_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .load_res_o  (load_res_o),
    .store_res_o (store_res_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ------------------------------
  // Four-phase memory model
  // ------------------------------
  initial begin : memory_model
    logic [2:0] delay;
    logic [5:0] idx;
    lfsr        = 32'h905d_401a;
    handshakes  = 0;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hc0de_0000 | (32'(i) << 2);
    end
    forever begin
      @(posedge clk_i);
      #2;
      if (mem_req_o) begin
        delay = '0;
        for (int b = 0; b < 3; b++) begin
          lfsr  = lfsr_next(lfsr);
          delay = {delay[1:0], lfsr[0]};
        end
        repeat (delay) begin
          @(posedge clk_i);
          #2;
        end
        idx         = mem_cmd_o.addr[7:2];
        mem_rdata_i = mem[idx];
        if (mem_cmd_o.we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_cmd_o.be[b]) begin
              mem[idx][8*b +: 8] = mem_cmd_o.wdata[8*b +: 8];
            end
          end
        end
        mem_ack_i  = 1'b1;
        handshakes = handshakes + 1;
        // Ack stays up until the request has dropped
        do begin
          @(posedge clk_i);
          #2;
        end while (mem_req_o);
        mem_ack_i = 1'b0;
      end
    end
  end

  // Every valid result counted, both ports at once is an error
  initial begin : result_monitor
    results      = 0;
    dual_results = 0;
    forever begin
      @(posedge clk_i);
      #2;
      if (load_res_o.valid && store_res_o.valid) begin
        dual_results = dual_results + 1;
      end
      if (load_res_o.valid || store_res_o.valid) begin
        results = results + 1;
      end
    end
  end

  initial cycles = 0;
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped, no completion within %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin : stimulus
    vector_t     v;
    lsu_result_t res;
    logic        seen_req;
    logic        is_load;
    int          errors;
    int          aligned;
    errors      = 0;
    aligned     = 0;
    rst_ni      = 1'b0;
    lsu_valid_i = 1'b0;
    fu_data_i   = '0;
    // op, base, imm, store data, trans_id, result, exception valid, cause, tval
    vecs[0]  = '{SW,  'h40, 'h0, 'h8899_aabb, 3'd1, 'h0, 1'b0, CAUSE_NONE, 'h0};
    vecs[1]  = '{LW,  'h40, 'h0, 'h0, 3'd2, 'h8899_aabb, 1'b0, CAUSE_NONE, 'h0};
    vecs[2]  = '{SW,  'h50, 'h0, 'h1234_5678, 3'd3, 'h0, 1'b0, CAUSE_NONE, 'h0};
    vecs[3]  = '{SB,  'h50, 'h1, 'h0000_00f0, 3'd4, 'h0, 1'b0, CAUSE_NONE, 'h0};
    vecs[4]  = '{SH,  'h50, 'h2, 'h0000_8001, 3'd5, 'h0, 1'b0, CAUSE_NONE, 'h0};
    vecs[5]  = '{LB,  'h50, 'h1, 'h0, 3'd6, 'hffff_fff0, 1'b0, CAUSE_NONE, 'h0};
    vecs[6]  = '{LBU, 'h50, 'h1, 'h0, 3'd7, 'h0000_00f0, 1'b0, CAUSE_NONE, 'h0};
    vecs[7]  = '{LH,  'h50, 'h2, 'h0, 3'd0, 'hffff_8001, 1'b0, CAUSE_NONE, 'h0};
    vecs[8]  = '{LHU, 'h50, 'h2, 'h0, 3'd1, 'h0000_8001, 1'b0, CAUSE_NONE, 'h0};
    vecs[9]  = '{LB,  'h50, 'h0, 'h0, 3'd2, 'h0000_0078, 1'b0, CAUSE_NONE, 'h0};
    vecs[10] = '{LW,  'h60, 'hffff_fff0, 'h0, 3'd3, 'h8001_f078, 1'b0, CAUSE_NONE, 'h0};
    vecs[11] = '{LH,  'h40, 'h1, 'h0, 3'd4, 'h0, 1'b1, CAUSE_LD_MISALIGNED, 'h41};
    vecs[12] = '{LW,  'h40, 'h2, 'h0, 3'd5, 'h0, 1'b1, CAUSE_LD_MISALIGNED, 'h42};
    vecs[13] = '{SH,  'h40, 'h3, 'hdead, 3'd6, 'h0, 1'b1, CAUSE_ST_MISALIGNED, 'h43};
    vecs[14] = '{SW,  'h44, 'hffff_fffe, 'h5555, 3'd7, 'h0, 1'b1, CAUSE_ST_MISALIGNED, 'h42};
    vecs[15] = '{LW,  'h40, 'h0, 'h0, 3'd0, 'h8899_aabb, 1'b0, CAUSE_NONE, 'h0};
    vecs[16] = '{LH,  'h40, 'h0, 'h0, 3'd1, 'hffff_aabb, 1'b0, CAUSE_NONE, 'h0};
    vecs[17] = '{LBU, 'h40, 'h3, 'h0, 3'd2, 'h0000_0088, 1'b0, CAUSE_NONE, 'h0};
    vecs[18] = '{LB,  'h40, 'h3, 'h0, 3'd3, 'hffff_ff88, 1'b0, CAUSE_NONE, 'h0};

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    if (!lsu_ready_o || mem_req_o || load_res_o.valid || store_res_o.valid) begin
      errors++;
      $display("DUT is not idle after reset");
    end

    for (int n = 0; n < NUM_VEC; n++) begin
      v                   = vecs[n];
      is_load             = v.op inside {LB, LH, LW, LBU, LHU};
      fu_data_i.op        = v.op;
      fu_data_i.operand_a = v.base;
      fu_data_i.operand_b = v.wdata;
      fu_data_i.imm       = v.imm;
      fu_data_i.trans_id  = v.id;
      lsu_valid_i         = 1'b1;
      while (!lsu_ready_o) begin
        @(posedge clk_i);
        #2;
      end
      // Accepted on this edge
      @(posedge clk_i);
      #2;
      lsu_valid_i = 1'b0;
      seen_req    = 1'b0;
      while (!load_res_o.valid && !store_res_o.valid) begin
        if (mem_req_o) begin
          seen_req = 1'b1;
        end
        if (lsu_ready_o) begin
          errors++;
          $display("Ready went high before instruction %0d completed", n);
        end
        @(posedge clk_i);
        #2;
      end
      res = is_load ? load_res_o : store_res_o;
      if (!res.valid) begin
        errors++;
        $display("Instruction %0d returned its result on the wrong port", n);
      end
      if (res.trans_id !== v.id) begin
        errors++;
        $display("ERROR trans_id: got %h expected %h (entry %0d)", res.trans_id, v.id, n);
      end
      if (res.result !== v.exp_res) begin
        errors++;
        $display("ERROR result: got %h expected %h (entry %0d)", res.result, v.exp_res, n);
      end
      if (res.ex.valid !== v.exp_ex) begin
        errors++;
        $display("ERROR ex.valid: got %h expected %h (entry %0d)", res.ex.valid, v.exp_ex, n);
      end
      if (v.exp_ex && (res.ex.cause !== v.exp_cause)) begin
        errors++;
        $display("ERROR ex.cause: got %h expected %h (entry %0d)", res.ex.cause, v.exp_cause, n);
      end
      if (v.exp_ex && (res.ex.tval !== v.exp_tval)) begin
        errors++;
        $display("ERROR ex.tval: got %h expected %h (entry %0d)", res.ex.tval, v.exp_tval, n);
      end
      if (seen_req === v.exp_ex) begin
        errors++;
        $display("Memory request activity wrong for instruction %0d", n);
      end
      if (!v.exp_ex) begin
        aligned++;
      end
    end

    repeat (2) @(posedge clk_i);
    #2;
    if (results != NUM_VEC || dual_results != 0) begin
      errors++;
      $display("Expected one result per instruction, saw %0d results", results);
    end
    if (handshakes != aligned) begin
      errors++;
      $display("Expected %0d memory handshakes, saw %0d", aligned, handshakes);
    end
    $display("Errors: %0d  Results: %0d of %0d  Handshakes: %0d", errors, results, NUM_VEC,
             handshakes);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsu_top.f */
source/lsu_pkg.sv
source/lsu_agu.sv
source/lsu_mem_ctrl.sv
source/lsu_load_align.sv
source/lsu_pipe_reg.sv
source/lsu_top.sv
test/lsu_top_sva.sv
test/tb_lsu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the LSU testbench with Verilator, run it and scan the log for failure

rm -f sim.log
verilator --binary --timing --assert -f lsu_top.f --top-module tb_lsu_top -o tb_lsu_top \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_lsu_top > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
